/* verification/ps2_input.txt */
// columns cmd_flag_byte_status_code. cmd 1 frame (flag bad parity, code expected set 1)
// cmd 2 pop, 3 flush, 4 read (flag bytesel), 5 read then pop, 6 irq tally check
4_3_00_00_00 // empty after reset
1_0_1c_00_1e // a make
5_3_00_01_1e
4_3_00_00_00
1_0_f0_00_00 // break prefix
1_0_1c_00_9e // a break
1_0_e0_00_e0 // extended prefix
5_3_00_01_9e
5_3_00_01_e0
1_1_24_00_00 // bad parity
4_1_00_02_00 // low lane read keeps the error
4_3_00_02_00 // clears it
4_3_00_00_00
1_0_55_00_00 // unmapped
4_3_00_00_00
1_0_16_00_02 // ten codes, eight fit
1_0_1e_00_03
1_0_26_00_04
1_0_25_00_05
1_0_5a_00_1c
1_0_29_00_39
1_0_76_00_01
1_0_66_00_0e
1_0_0d_00_0f
1_0_12_00_2a
5_3_00_01_02
5_3_00_01_03
5_3_00_01_04
5_3_00_01_05
5_3_00_01_1c
5_3_00_01_39
5_3_00_01_01
5_3_00_01_0e
4_3_00_00_00
1_0_29_00_39 // flush test
1_0_76_00_01
1_0_66_00_0e
3_0_00_00_00
4_3_00_00_00
6_0_00_00_00 // irq tally

/* tb.f */
src/ps2_pkg.sv
src/ps2_rx.sv
src/scancode_translator.sv
src/scan_fifo.sv
src/ps2_kbd_controller.sv
verification/ps2_kbd_controller_sva.sv
verification/tb_ps2_kbd_controller.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ps2_kbd_controller
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_ps2_kbd_controller.sv */
// testbench for the ps2 keyboard controller
// reads frame and cpu commands from a vector file, drives ps2 frames
// and cpu bus accesses, and checks read data and irq pulses against
// the expected values and a reference model of the code queue
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_kbd_controller
    import ps2_pkg::*;
;

    localparam int fifo_depth   = default_fifo_depth;
    localparam int idle_timeout = 200;
    // ps2 clock half period in system clocks
    localparam int ps2_half     = 8;
    localparam int max_vectors  = 64;

    logic        clk;
    logic        reset;
    logic        cs;
    cpu_req_t    req;
    logic        ack;
    logic [15:0] rdata;
    logic        irq;
    logic        ps2_clk;
    logic        ps2_dat;

    logic [31:0] vectors [max_vectors];
    logic [7:0]  model_q [$];
    logic [31:0] lfsr;
    int          n_vec;
    int          limit;
    int          cycles;
    int          irq_count;
    int          model_writes;
    int          mismatches;
    int          other_errors;

    ps2_kbd_controller #(
        .fifo_depth  (fifo_depth),
        .idle_timeout(idle_timeout)
    ) u_ps2_kbd_controller (
        .clk    (clk),
        .reset  (reset),
        .cs     (cs),
        .req    (req),
        .ack    (ack),
        .rdata  (rdata),
        .irq    (irq),
        .ps2_clk(ps2_clk),
        .ps2_dat(ps2_dat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // tally of irq pulses seen on the dut
    always @(posedge clk) begin
        if (!reset && irq)
            irq_count++;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = val * 2 + int'(lfsr[0]);
        end
        return val;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // start, 8 data bits lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        logic        parity;
        parity = ~(^data) ^ bad_parity;
        frame  = {1'b1, parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = frame[i];
            wait_cycles(ps2_half);
            ps2_clk = 1'b0;
            wait_cycles(ps2_half);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        // random idle gap between frames
        wait_cycles(ps2_half + take_bits(4));
    endtask

    // one cpu access, waits for ack and returns rdata
    task automatic cpu_access(input logic wr, input logic [1:0] sel,
                              input logic [15:0] wdata, output logic [15:0] got);
        int waited;
        cs          = 1'b1;
        req.access  = 1'b1;
        req.wr_en   = wr;
        req.bytesel = sel;
        req.wdata   = wdata;
        @(negedge clk);
        cs     = 1'b0;
        req    = '0;
        waited = 0;
        while (!ack && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            other_errors++;
            $display("no acknowledge for cpu access at %0t", $time);
        end
        got = rdata;
    endtask

    task automatic pop_head();
        logic [15:0] word;
        logic [15:0] got;
        word          = 16'h0000;
        word[pop_bit] = 1'b1;
        cpu_access(1'b1, 2'b11, word, got);
        // writes return zero read data
        check_rdata(kbd_status_t'(got[15:8]), got[7:0], kbd_status_t'(8'h00), 8'h00);
        if (model_q.size() != 0)
            void'(model_q.pop_front());
    endtask

    task automatic flush_queue();
        logic [15:0] word;
        logic [15:0] got;
        word            = 16'h0000;
        word[flush_bit] = 1'b1;
        cpu_access(1'b1, 2'b11, word, got);
        check_rdata(kbd_status_t'(got[15:8]), got[7:0], kbd_status_t'(8'h00), 8'h00);
        model_q.delete();
    endtask

    task automatic check_rdata(input kbd_status_t got_status, input logic [7:0] got_code,
                               input kbd_status_t exp_status, input logic [7:0] exp_code);
        if (got_status !== exp_status || got_code !== exp_code) begin
            mismatches++;
            $display("Mismatch at %0t: read status %b code %h, expected status %b code %h",
                     $time, got_status, got_code, exp_status, exp_code);
        end
    endtask

    task automatic check_irq_count(input int got, input int exp);
        if (got != exp) begin
            mismatches++;
            $display("Mismatch at %0t: %0d irq pulses, expected %0d", $time, got, exp);
        end
    endtask

    // run limit from the number of vectors
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        logic [31:0] vec;
        logic [15:0] got;
        logic [7:0]  head;
        reset        = 1'b1;
        cs           = 1'b0;
        req          = '0;
        ps2_clk      = 1'b1;
        ps2_dat      = 1'b1;
        lfsr         = 32'hce53_2449;
        irq_count    = 0;
        model_writes = 0;
        mismatches   = 0;
        other_errors = 0;
        limit        = 0;
        for (int i = 0; i < max_vectors; i++)
            vectors[i] = 32'h0;
        $readmemh("verification/ps2_input.txt", vectors);
        // command 0 ends the list
        n_vec = 0;
        while (n_vec < max_vectors && vectors[n_vec][31:28] != 4'h0)
            n_vec++;
        limit = n_vec * 120;
        wait_cycles(5);
        reset = 1'b0;
        wait_cycles(2);
        for (int i = 0; i < n_vec; i++) begin
            vec = vectors[i];
            case (vec[31:28])
                4'h1: begin
                    send_frame(vec[23:16], vec[24]);
                    // zero codes never enter, a full queue drops
                    if (vec[7:0] != 8'h00 && model_q.size() < fifo_depth) begin
                        model_q.push_back(vec[7:0]);
                        model_writes++;
                    end
                end
                4'h2: pop_head();
                4'h3: flush_queue();
                4'h4, 4'h5: begin
                    cpu_access(1'b0, vec[25:24], 16'h0000, got);
                    check_rdata(kbd_status_t'(got[15:8]), got[7:0],
                                kbd_status_t'(vec[15:8]), vec[7:0]);
                    head = (model_q.size() != 0) ? model_q[0] : 8'h00;
                    if (head != vec[7:0]) begin
                        other_errors++;
                        $display("vector %0d expects code %h but queue model holds %h",
                                 i, vec[7:0], head);
                    end
                    if (vec[31:28] == 4'h5)
                        pop_head();
                end
                4'h6: check_irq_count(irq_count, model_writes);
                default: begin
                    other_errors++;
                    $display("vector %0d has unknown command %h", i, vec[31:28]);
                end
            endcase
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/ps2_kbd_controller_sva.sv */
// assertions for the ps2 keyboard controller
// ack one cycle after each access, every irq leaves a code queued,
// a full queue stays full until popped or flushed
`timescale 1ns/1ps
`default_nettype none

module ps2_kbd_controller_sva
    import ps2_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     cs,
    input cpu_req_t req,
    input logic     ack,
    input logic     irq,
    input logic     full,
    input logic     empty,
    input logic     pop,
    input logic     flush
);

    ack_after_access: assert property (@(posedge clk) disable iff (reset)
        (cs && req.access) |=> ack)
        else $error("ack missing one cycle after an access");

    no_ack_without_access: assert property (@(posedge clk) disable iff (reset)
        !(cs && req.access) |=> !ack)
        else $error("ack without a preceding access");

    // an accepted code must show up in the queue
    irq_adds_entry: assert property (@(posedge clk) disable iff (reset)
        (irq && !flush) |=> !empty)
        else $error("irq raised but the queue is empty afterwards");

    // dropped codes must not disturb a full queue
    full_holds: assert property (@(posedge clk) disable iff (reset)
        (full && !pop && !flush) |=> full)
        else $error("full queue lost an entry without a pop or flush");

endmodule

bind ps2_kbd_controller ps2_kbd_controller_sva u_ps2_kbd_controller_sva (
    .clk  (clk),
    .reset(reset),
    .cs   (cs),
    .req  (req),
    .ack  (ack),
    .irq  (irq),
    .full (full),
    .empty(empty),
    .pop  (fifo_rd_en),
    .flush(fifo_flush)
);

`default_nettype wire

/* src/ps2_kbd_controller.sv */
// ps2 keyboard controller
// receives keyboard frames, translates set 2 to set 1 and queues the
// codes for the cpu. the cpu port acks one cycle after an access;
// reads return the status byte and head code, writes pop or flush.
// irq pulses once for every code that enters the queue
`timescale 1ns/1ps
`default_nettype none

module ps2_kbd_controller
    import ps2_pkg::*;
#(
    parameter int fifo_depth   = default_fifo_depth,
    parameter int idle_timeout = default_idle_timeout
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cs,
    input  cpu_req_t    req,
    output logic        ack,
    output logic [15:0] rdata,
    output logic        irq,
    input  logic        ps2_clk,
    input  logic        ps2_dat
);

    logic        do_read;
    logic        do_write;
    logic        rx_valid;
    rx_byte_t    rx;
    logic        scancode_valid;
    logic [7:0]  scancode;
    logic        fifo_wr_en;
    logic        fifo_rd_en;
    logic        fifo_flush;
    logic [7:0]  fifo_rd_data;
    logic        empty;
    logic        full;
    logic        unread_error;
    kbd_status_t status;
    logic [7:0]  head_code;

    // cpu access decode
    assign do_read  = cs & req.access & ~req.wr_en;
    assign do_write = cs & req.access & req.wr_en;

    // pop and flush only act through the high byte lane
    assign fifo_rd_en = do_write & req.bytesel[1] & req.wdata[pop_bit] & ~empty;
    assign fifo_flush = do_write & req.bytesel[1] & req.wdata[flush_bit];

    // zero codes are unmapped keys, dropped along with codes hitting a full queue
    assign fifo_wr_en = scancode_valid & (|scancode) & ~full;
    assign irq        = fifo_wr_en;

    assign status.reserved     = 6'b0;
    assign status.unread_error = unread_error;
    assign status.not_empty    = ~empty;
    assign head_code           = empty ? 8'h00 : fifo_rd_data;

    ps2_rx #(
        .idle_timeout(idle_timeout)
    ) u_ps2_rx (
        .clk     (clk),
        .reset   (reset),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .rx_valid(rx_valid),
        .rx      (rx)
    );

    scancode_translator u_scancode_translator (
        .clk           (clk),
        .reset         (reset),
        .rx_valid      (rx_valid),
        .rx            (rx),
        .scancode_valid(scancode_valid),
        .scancode      (scancode)
    );

    scan_fifo #(
        .width(8),
        .depth(fifo_depth)
    ) u_scan_fifo (
        .clk    (clk),
        .reset  (reset),
        .flush  (fifo_flush),
        .wr_en  (fifo_wr_en),
        .wr_data(scancode),
        .rd_en  (fifo_rd_en),
        .rd_data(fifo_rd_data),
        .empty  (empty),
        .full   (full)
    );

    // registered cpu response, ack one cycle after any access
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack   <= 1'b0;
            rdata <= 16'h0000;
        end else begin
            ack   <= cs & req.access;
            rdata <= do_read ? {status, head_code} : 16'h0000;
        end
    end

    // error latch, set by a bad frame and cleared by a status read
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            unread_error <= 1'b0;
        else if (rx_valid && rx.error)
            unread_error <= 1'b1;
        else if (do_read && req.bytesel[1])
            unread_error <= 1'b0;
    end

endmodule

`default_nettype wire

/* src/scan_fifo.sv */
// scan code queue
// circular buffer with read and write pointers and an occupancy
// counter. head entry is visible on rd_data with no read latency;
// flush empties the queue in one cycle
`timescale 1ns/1ps
`default_nettype none

module scan_fifo #(
    parameter int width = 8,
    parameter int depth = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    input  logic             wr_en,
    input  logic [width-1:0] wr_data,
    input  logic             rd_en,
    output logic [width-1:0] rd_data,
    output logic             empty,
    output logic             full
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign empty   = (count == '0);
    assign full    = (count == cnt_w'(depth));
    assign do_wr   = wr_en & ~full;
    assign do_rd   = rd_en & ~empty;
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at depth, not only at powers of two
            if (do_wr)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_wr && !flush)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

/* src/scancode_translator.sv */
// scan code translator
// converts a fixed set of 16 set 2 codes to set 1. F0 sets a break
// flag that marks the next code with bit 7; E0 is passed as a code of
// its own. unmapped codes come out as zero
`timescale 1ns/1ps
`default_nettype none

module scancode_translator
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_valid,
    input  rx_byte_t   rx,
    output logic       scancode_valid,
    output logic [7:0] scancode
);

    logic       good_byte;
    logic       break_flag;
    logic [7:0] mapped;

    // error frames are ignored entirely
    assign good_byte = rx_valid & ~rx.error;

    // set 2 to set 1 lookup
    always_comb begin
        case (rx.data)
            8'h1c: mapped = 8'h1e;  // a
            8'h32: mapped = 8'h30;  // b
            8'h21: mapped = 8'h2e;  // c
            8'h23: mapped = 8'h20;  // d
            8'h24: mapped = 8'h12;  // e
            8'h2b: mapped = 8'h21;  // f
            8'h16: mapped = 8'h02;  // 1
            8'h1e: mapped = 8'h03;  // 2
            8'h26: mapped = 8'h04;  // 3
            8'h25: mapped = 8'h05;  // 4
            8'h5a: mapped = 8'h1c;  // enter
            8'h29: mapped = 8'h39;  // space
            8'h76: mapped = 8'h01;  // escape
            8'h66: mapped = 8'h0e;  // backspace
            8'h0d: mapped = 8'h0f;  // tab
            8'h12: mapped = 8'h2a;  // left shift
            default: mapped = 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            break_flag     <= 1'b0;
            scancode_valid <= 1'b0;
        end else begin
            // F0 itself gives no strobe
            scancode_valid <= good_byte & (rx.data != set2_break);
            if (good_byte) begin
                if (rx.data == set2_break)
                    break_flag <= 1'b1;
                else if (rx.data != set2_extended)
                    break_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (good_byte) begin
            if (rx.data == set2_extended)
                scancode <= set2_extended;
            else if (mapped != 8'h00 && break_flag)
                scancode <= mapped | 8'h80;
            else
                scancode <= mapped;
        end
    end

endmodule

`default_nettype wire

/* src/ps2_rx.sv */
// ps2 frame receiver
// synchronises the keyboard clock and data lines, samples data on each
// falling clock edge and assembles 11-bit frames. start, parity and
// stop are checked; a stalled frame is dropped after idle_timeout cycles
`timescale 1ns/1ps
`default_nettype none

module ps2_rx
    import ps2_pkg::*;
#(
    parameter int idle_timeout = default_idle_timeout
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     ps2_clk,
    input  logic     ps2_dat,
    output logic     rx_valid,
    output rx_byte_t rx
);

    localparam int idle_w = $clog2(idle_timeout + 1);

    // two stage synchronisers, idle level is high
    logic [1:0]        clk_sync;
    logic [1:0]        dat_sync;
    logic              clk_prev;
    logic              falling;
    logic [10:0]       shift_reg;
    logic [10:0]       frame_next;
    logic [3:0]        bit_cnt;
    logic [idle_w-1:0] idle_cnt;
    logic              frame_error;

    assign falling = clk_prev & ~clk_sync[1];

    // frame as it looks once the current bit is shifted in
    // bit 0 start, 8:1 data lsb first, 9 parity, 10 stop
    assign frame_next = {dat_sync[1], shift_reg[10:1]};

    // odd parity over data and parity bit
    assign frame_error = frame_next[0] | ~frame_next[10] | ~(^frame_next[9:1]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // bit counter, idle timeout and frame strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_cnt  <= 4'd0;
            idle_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (falling) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    // stop bit taken, frame done
                    bit_cnt  <= 4'd0;
                    rx_valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                // partial frame, watch for a stalled keyboard
                if (idle_cnt == idle_w'(idle_timeout - 1)) begin
                    bit_cnt  <= 4'd0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end else begin
                idle_cnt <= '0;
            end
        end
    end

    // payload, no reset needed
    always_ff @(posedge clk) begin
        if (falling) begin
            shift_reg <= frame_next;
            if (bit_cnt == 4'd10) begin
                rx.data  <= frame_next[8:1];
                rx.error <= frame_error;
            end
        end
    end

endmodule

`default_nettype wire

/* src/ps2_pkg.sv */
// ps2 keyboard shared definitions
// cpu bus request, status byte and received frame structs,
// set 2 prefix bytes, control bits of the cpu port and parameter defaults
`default_nettype none

package ps2_pkg;

    // one cpu bus request, 20 bits
    typedef struct packed {
        logic        access;
        logic        wr_en;
        logic [1:0]  bytesel;
        logic [15:0] wdata;
    } cpu_req_t;

    // status byte, returned as the high byte of read data
    typedef struct packed {
        logic [5:0] reserved;
        logic       unread_error;
        logic       not_empty;
    } kbd_status_t;

    // one received ps2 frame
    typedef struct packed {
        logic [7:0] data;
        logic       error;
    } rx_byte_t;

    // scan code set 2 prefixes
    localparam logic [7:0] set2_break    = 8'hf0;
    localparam logic [7:0] set2_extended = 8'he0;

    // write data bits of the cpu port
    localparam int pop_bit   = 15;
    localparam int flush_bit = 14;

    // top level defaults
    localparam int default_fifo_depth   = 8;
    localparam int default_idle_timeout = 20000;

endpackage

`default_nettype wire
